//--- project.f
source/oramPkg.sv
source/hashPkg.sv
source/bucketRam.sv
source/bucketHashEngine.sv
source/pendingFifo.sv
source/integrityVerifier.sv
source/integrityTop.sv
tb/integrityChecker.sv
tb/integrityTb.sv

//--- run.sh
#!/bin/sh
# build and run the integrity verifier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module integrityTb \
	-f project.f \
	-o integritySim

./obj_dir/integritySim | tee sim.log

# the run counts as passed only if the pass line was printed
grep -qx "PASS: all tests" sim.log

//--- source/bucketHashEngine.sv
`timescale 1ns/10ps

module bucketHashEngine #(
	parameter int AbsorbWords = 5
) (
	input logic Clock,
	input logic rst,
	output logic DataInReady,
	input logic DataInValid,
	input oramPkg::wordT DataIn,
	input logic HashOutReady,
	output logic HashOutValid,
	output hashPkg::digestT HashOut
);

	import hashPkg::*;

	localparam int WordCountWidth = $clog2(AbsorbWords + 1);
	localparam int RoundCountWidth = $clog2(HashRounds + 1);

	typedef enum logic [1:0] {
		Absorb,
		Finalize,
		Hold
	} phaseT;

	phaseT phase;
	logic [WordCountWidth-1:0] wordCount;
	logic [RoundCountWidth-1:0] roundCount;
	digestT state;
	digestT roundIn;
	logic dataTake;
	logic lastWord;
	logic lastRound;

	// ==============================
	// handshake
	// ==============================

	// idle is simply absorb with no word taken yet
	assign DataInReady = (phase == Absorb);
	assign HashOutValid = (phase == Hold);
	assign HashOut = state;

	assign dataTake = DataInValid && DataInReady;
	assign lastWord = (wordCount == WordCountWidth'(AbsorbWords - 1));
	assign lastRound = (roundCount == RoundCountWidth'(HashRounds - 1));

	// the word count is folded in on the first finalize round
	assign roundIn = (roundCount == '0) ? (state ^ digestT'(AbsorbWords)) : state;

	// ==============================
	// phase and state update
	// ==============================

	always_ff @(posedge Clock) begin
		if (rst) begin
			phase <= Absorb;
			wordCount <= '0;
			roundCount <= '0;
			state <= SpongeIv;
		end else begin
			case (phase)
				Absorb: begin
					if (dataTake) begin
						state <= spongeRound(state ^ DataIn, RoundConstants[0]);
						if (lastWord) begin
							wordCount <= '0;
							roundCount <= '0;
							phase <= Finalize;
						end else begin
							wordCount <= wordCount + 1'b1;
						end
					end
				end
				Finalize: begin
					state <= spongeRound(roundIn, RoundConstants[roundCount]);
					if (lastRound) begin
						phase <= Hold;
					end else begin
						roundCount <= roundCount + 1'b1;
					end
				end
				Hold: begin
					// valid is high here, so ready alone completes the transfer
					if (HashOutReady) begin
						state <= SpongeIv;
						phase <= Absorb;
					end
				end
				default: begin
					phase <= Absorb;
				end
			endcase
		end
	end

	// the verifier checks readiness once per bucket, then streams words blindly
	assert property (@(posedge Clock) disable iff (rst) DataInValid |-> DataInReady)
		else $error("word offered to a busy hash engine");

endmodule

//--- source/bucketRam.sv
`timescale 1ns/10ps

module bucketRam #(
	parameter int Depth = 1024
) (
	input logic Clock,
	input logic rst,
	input logic WriteEnable,
	input oramPkg::addrT WriteAddress,
	input oramPkg::wordT WriteData,
	input logic ReadRequest,
	input oramPkg::addrT ReadAddress,
	output oramPkg::wordT ReadData
);

	import oramPkg::*;

	// data words and tag words of all buckets
	wordT mem [Depth];

	// host side fill port
	always_ff @(posedge Clock) begin
		if (WriteEnable) begin
			mem[WriteAddress] <= WriteData;
		end
	end

	// registered read, data valid the cycle after the request
	always_ff @(posedge Clock) begin
		if (rst) begin
			ReadData <= '0;
		end else if (ReadRequest) begin
			ReadData <= mem[ReadAddress];
		end
	end

endmodule

//--- source/hashPkg.sv
package hashPkg;

	// ==============================
	// sponge constants
	// ==============================

	localparam int DigestWidth = 64;

	typedef logic [DigestWidth-1:0] digestT;

	// starting state of every bucket hash
	localparam digestT SpongeIv = 64'h6a09e667f3bcc908;

	// rounds run after the last absorbed word
	localparam int HashRounds = 4;

	localparam int RotateAmount = 13;

	// index 0 is also the absorb constant
	localparam logic [0:HashRounds-1][DigestWidth-1:0] RoundConstants = {
		64'h0000000000000001,
		64'h0000000000008082,
		64'h800000000000808a,
		64'h8000000080008000
	};

	// ==============================
	// add-rotate-xor round
	// ==============================

	// add the constant, rotate left, xor back with the input state
	function automatic digestT spongeRound(digestT state, digestT roundConst);
		digestT sum;
		sum = state + roundConst;
		return ((sum << RotateAmount) | (sum >> (DigestWidth - RotateAmount))) ^ state;
	endfunction

endpackage

//--- source/integrityTop.sv
`timescale 1ns/10ps

module integrityTop #(
	parameter int NumEngines = 3,
	parameter int BucketWords = 4,
	parameter int FifoDepth = 4
) (
	input logic Clock,
	input logic rst,
	input logic HostWrite,
	input oramPkg::addrT HostAddress,
	input oramPkg::wordT HostData,
	input logic Start,
	input oramPkg::bucketIdT FirstBucket,
	input oramPkg::bucketIdT BucketCount,
	output logic ResultValid,
	output oramPkg::bucketIdT ResultBucket,
	output logic ResultOk,
	output logic Done
);

	import oramPkg::*;
	import hashPkg::*;

	logic ReadRequest;
	addrT ReadAddress;
	wordT ReadData;
	logic [NumEngines-1:0] DataInReady;
	logic [NumEngines-1:0] DataInValid;
	wordT DataIn;
	logic [NumEngines-1:0] HashOutValid;
	digestT HashOut [NumEngines];
	logic [NumEngines-1:0] HashOutReady;

	bucketRam #(
		.Depth(2 ** AddrWidth)
	) bucketRam_i (
		.Clock(Clock),
		.rst(rst),
		.WriteEnable(HostWrite),
		.WriteAddress(HostAddress),
		.WriteData(HostData),
		.ReadRequest(ReadRequest),
		.ReadAddress(ReadAddress),
		.ReadData(ReadData)
	);

	integrityVerifier #(
		.NumEngines(NumEngines),
		.BucketWords(BucketWords),
		.FifoDepth(FifoDepth)
	) integrityVerifier_i (
		.Clock(Clock),
		.rst(rst),
		.Start(Start),
		.FirstBucket(FirstBucket),
		.BucketCount(BucketCount),
		.ReadRequest(ReadRequest),
		.ReadAddress(ReadAddress),
		.ReadData(ReadData),
		.DataInReady(DataInReady),
		.DataInValid(DataInValid),
		.DataIn(DataIn),
		.HashOutValid(HashOutValid),
		.HashOut(HashOut),
		.HashOutReady(HashOutReady),
		.ResultValid(ResultValid),
		.ResultBucket(ResultBucket),
		.ResultOk(ResultOk),
		.Done(Done)
	);

	// data words plus the bucket id go through each engine
	for (genvar k = 0; k < NumEngines; k++) begin : hashEngines
		bucketHashEngine #(
			.AbsorbWords(BucketWords + 1)
		) bucketHashEngine_i (
			.Clock(Clock),
			.rst(rst),
			.DataInReady(DataInReady[k]),
			.DataInValid(DataInValid[k]),
			.DataIn(DataIn),
			.HashOutReady(HashOutReady[k]),
			.HashOutValid(HashOutValid[k]),
			.HashOut(HashOut[k])
		);
	end

endmodule

//--- source/integrityVerifier.sv
`timescale 1ns/10ps

module integrityVerifier #(
	parameter int NumEngines = 3,
	parameter int BucketWords = 4,
	parameter int FifoDepth = 4
) (
	input logic Clock,
	input logic rst,
	input logic Start,
	input oramPkg::bucketIdT FirstBucket,
	input oramPkg::bucketIdT BucketCount,
	output logic ReadRequest,
	output oramPkg::addrT ReadAddress,
	input oramPkg::wordT ReadData,
	input logic [NumEngines-1:0] DataInReady,
	output logic [NumEngines-1:0] DataInValid,
	output oramPkg::wordT DataIn,
	input logic [NumEngines-1:0] HashOutValid,
	input hashPkg::digestT HashOut [NumEngines],
	output logic [NumEngines-1:0] HashOutReady,
	output logic ResultValid,
	output oramPkg::bucketIdT ResultBucket,
	output logic ResultOk,
	output logic Done
);

	import oramPkg::*;

	localparam int TurnWidth = (NumEngines > 1) ? $clog2(NumEngines) : 1;
	localparam int IdxWidth = $clog2(BucketWords + 1);
	localparam int PendWidth = $clog2(FifoDepth + 1);

	logic busy;
	logic inBucket;
	logic [IdxWidth-1:0] wordIdx;
	addrT baseAddr;
	bucketIdT issueBucket;
	bucketIdT bucketsLeft;
	bucketIdT resultsLeft;
	logic [PendWidth-1:0] pendingTags;
	logic [TurnWidth-1:0] InTurn;
	logic [TurnWidth-1:0] OutTurn;
	logic canStart;
	logic tagRead;

	// read response stage, one cycle behind the request
	logic respValid;
	logic respIsTag;
	logic [TurnWidth-1:0] respEngine;
	bucketIdT respBucket;

	logic digestTaken;
	logic lastResult;
	tagEntryT headTag;
	logic Empty;

	// ==============================
	// bucket fetch sequencer
	// ==============================

	// a bucket starts only when its engine is free and its tag has a queue slot;
	// the engine still taking the previous id word does not count as free
	assign canStart = busy && (bucketsLeft != '0) && !inBucket && DataInReady[InTurn]
		&& !(respValid && respEngine == InTurn)
		&& (pendingTags != PendWidth'(FifoDepth));

	assign ReadRequest = inBucket || canStart;
	assign ReadAddress = baseAddr + addrT'(wordIdx);
	assign tagRead = ReadRequest && (wordIdx == IdxWidth'(BucketWords));

	always_ff @(posedge Clock) begin
		if (rst) begin
			busy <= 1'b0;
			inBucket <= 1'b0;
			wordIdx <= '0;
			bucketsLeft <= '0;
			InTurn <= '0;
		end else begin
			if (Start && !busy && BucketCount != '0) begin
				busy <= 1'b1;
				baseAddr <= addrT'(FirstBucket) * addrT'(BucketWords + 1);
				issueBucket <= FirstBucket;
				bucketsLeft <= BucketCount;
			end else if (lastResult) begin
				busy <= 1'b0;
			end
			if (tagRead) begin
				inBucket <= 1'b0;
				wordIdx <= '0;
				baseAddr <= baseAddr + addrT'(BucketWords + 1);
				issueBucket <= issueBucket + 1'b1;
				bucketsLeft <= bucketsLeft - 1'b1;
				InTurn <= (InTurn == TurnWidth'(NumEngines - 1)) ? '0 : InTurn + 1'b1;
			end else if (ReadRequest) begin
				inBucket <= 1'b1;
				wordIdx <= wordIdx + 1'b1;
			end
		end
	end

	// ==============================
	// dispatch to engines
	// ==============================

	always_ff @(posedge Clock) begin
		if (rst) begin
			respValid <= 1'b0;
		end else begin
			respValid <= ReadRequest;
		end
		respIsTag <= tagRead;
		respEngine <= InTurn;
		respBucket <= issueBucket;
	end

	// the tag slot is replaced by the bucket id, so the id follows the last data word
	assign DataIn = respIsTag ? wordT'(respBucket) : ReadData;

	always_comb begin
		for (int k = 0; k < NumEngines; k++) begin
			DataInValid[k] = respValid && (respEngine == TurnWidth'(k));
			HashOutReady[k] = (OutTurn == TurnWidth'(k));
		end
	end

	pendingFifo #(
		.PayloadType(tagEntryT),
		.Depth(FifoDepth)
	) tagQueue_i (
		.Clock(Clock),
		.rst(rst),
		.Push(respValid && respIsTag),
		.PushData('{tag: ReadData, bucket: respBucket}),
		.Pop(digestTaken),
		.PopData(headTag),
		.Full(),
		.Empty(Empty)
	);

	// ==============================
	// digest comparison
	// ==============================

	assign digestTaken = HashOutValid[OutTurn] && HashOutReady[OutTurn];

	always_ff @(posedge Clock) begin
		if (rst) begin
			OutTurn <= '0;
			pendingTags <= '0;
			resultsLeft <= '0;
			ResultValid <= 1'b0;
			lastResult <= 1'b0;
			Done <= 1'b0;
		end else begin
			if (digestTaken) begin
				OutTurn <= (OutTurn == TurnWidth'(NumEngines - 1)) ? '0 : OutTurn + 1'b1;
			end
			// slots are claimed at bucket start, freed when the digest arrives
			if (canStart && !digestTaken) begin
				pendingTags <= pendingTags + 1'b1;
			end else if (digestTaken && !canStart) begin
				pendingTags <= pendingTags - 1'b1;
			end
			if (Start && !busy) begin
				resultsLeft <= BucketCount;
			end else if (digestTaken) begin
				resultsLeft <= resultsLeft - 1'b1;
			end
			ResultValid <= digestTaken;
			lastResult <= digestTaken && (resultsLeft == bucketIdT'(1));
			Done <= lastResult;
		end
		ResultOk <= (HashOut[OutTurn] == headTag.tag);
		ResultBucket <= headTag.bucket;
	end

	// the tag is queued while the engine is still finalizing
	assert property (@(posedge Clock) disable iff (rst) digestTaken |-> !Empty)
		else $error("digest arrived before its stored tag");

endmodule

//--- source/oramPkg.sv
package oramPkg;

	// ==============================
	// memory words and addressing
	// ==============================

	// one bucket word, also the width fed to the hash engines
	localparam int WordWidth = 64;

	typedef logic [WordWidth-1:0] wordT;

	// word address into the bucket memory
	localparam int AddrWidth = 10;

	typedef logic [AddrWidth-1:0] addrT;

	// ==============================
	// bucket identity
	// ==============================

	localparam int BucketIdWidth = 8;

	typedef logic [BucketIdWidth-1:0] bucketIdT;

	// stored tag waiting for its digest, tagged with the bucket it came from
	typedef struct packed {
		wordT tag;
		bucketIdT bucket;
	} tagEntryT;

endpackage

//--- source/pendingFifo.sv
`timescale 1ns/10ps

module pendingFifo #(
	parameter type PayloadType = logic [63:0],
	parameter int Depth = 4
) (
	input logic Clock,
	input logic rst,
	input logic Push,
	input PayloadType PushData,
	input logic Pop,
	output PayloadType PopData,
	output logic Full,
	output logic Empty
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	PayloadType slots [Depth];
	logic [PtrWidth-1:0] writePtr;
	logic [PtrWidth-1:0] readPtr;
	logic [CountWidth-1:0] count;

	assign Full = (count == CountWidth'(Depth));
	assign Empty = (count == '0);

	// show-ahead, head entry always visible
	assign PopData = slots[readPtr];

	always_ff @(posedge Clock) begin
		if (Push) begin
			slots[writePtr] <= PushData;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end else begin
			if (Push) begin
				writePtr <= (writePtr == PtrWidth'(Depth - 1)) ? '0 : writePtr + 1'b1;
			end
			if (Pop) begin
				readPtr <= (readPtr == PtrWidth'(Depth - 1)) ? '0 : readPtr + 1'b1;
			end
			if (Push && !Pop) begin
				count <= count + 1'b1;
			end else if (Pop && !Push) begin
				count <= count - 1'b1;
			end
		end
	end

	assert property (@(posedge Clock) disable iff (rst) Push |-> !Full)
		else $error("push into a full queue");

	assert property (@(posedge Clock) disable iff (rst) Pop |-> !Empty)
		else $error("pop from an empty queue");

endmodule

//--- tb/integrityChecker.sv
`timescale 1ns/10ps

module integrityChecker #(
	parameter int BucketWords = 4,
	parameter int NumBuckets = 32
) (
	input logic Clock,
	input logic rst,
	input logic Start,
	input oramPkg::bucketIdT FirstBucket,
	input oramPkg::bucketIdT BucketCount,
	input logic ResultValid,
	input oramPkg::bucketIdT ResultBucket,
	input logic ResultOk,
	input logic Done,
	input int ExpectedFails,
	input oramPkg::wordT Image [NumBuckets * (BucketWords + 1)],
	output hashPkg::digestT ModelTag [NumBuckets],
	output int TestCount,
	output int FailCount,
	output int ErrorCount
);

	import oramPkg::*;
	import hashPkg::*;

	localparam int Stride = BucketWords + 1;

	logic armed = 1'b0;
	bucketIdT expBucket = '0;
	bucketIdT testFirst = '0;
	bucketIdT testLength = '0;
	logic expOk = 1'b0;
	int remaining = 0;
	int received = 0;
	int lowCount = 0;
	int testErrors = 0;
	int tests = 0;
	int failedTests = 0;
	int errors = 0;

	assign TestCount = tests;
	assign FailCount = failedTests;
	assign ErrorCount = errors;

	// ==============================
	// reference sponge
	// ==============================

	function automatic digestT mixRound(digestT s, digestT c);
		digestT t;
		t = s + c;
		return {t[DigestWidth-1-RotateAmount:0], t[DigestWidth-1:DigestWidth-RotateAmount]} ^ s;
	endfunction

	// correct tag of every bucket for whatever data the image holds now
	always_comb begin : modelTags
		digestT acc;
		for (int b = 0; b < NumBuckets; b++) begin
			acc = SpongeIv;
			for (int w = 0; w < BucketWords; w++) begin
				acc = mixRound(acc ^ Image[b * Stride + w], RoundConstants[0]);
			end
			acc = mixRound(acc ^ digestT'(bucketIdT'(b)), RoundConstants[0]);
			acc = acc ^ digestT'(Stride);
			for (int r = 0; r < HashRounds; r++) begin
				acc = mixRound(acc, RoundConstants[r]);
			end
			ModelTag[b] = acc;
		end
	end

	task automatic countError();
		errors = errors + 1;
		if (armed) begin
			testErrors = testErrors + 1;
		end
	endtask

	// ==============================
	// result comparison
	// ==============================

	always @(posedge Clock) begin
		if (rst) begin
			armed = 1'b0;
		end else begin
			if (ResultValid) begin
				if (!armed) begin
					$display("result for bucket %0d arrived with no run in progress", ResultBucket);
					countError();
				end else if (remaining == 0) begin
					$display("extra result for bucket %0d after all %0d results", ResultBucket,
						testLength);
					countError();
				end else begin
					expOk = (ModelTag[int'(expBucket)] ==
						Image[int'(expBucket) * Stride + BucketWords]);
					if (ResultBucket !== expBucket) begin
						$display("error ResultBucket exp %h got %h", expBucket, ResultBucket);
						countError();
					end
					if (ResultOk !== expOk) begin
						$display("error ResultOk exp %h got %h for bucket %0d", expOk, ResultOk,
							expBucket);
						countError();
					end
					if (ResultOk === 1'b0) begin
						lowCount = lowCount + 1;
					end
					expBucket = expBucket + 8'd1;
					remaining = remaining - 1;
					received = received + 1;
				end
			end
			if (Done) begin
				if (!armed) begin
					$display("Done pulsed with no run in progress");
					countError();
				end else begin
					if (remaining != 0) begin
						$display("%0d results missing when Done arrived", remaining);
						countError();
					end
					if (lowCount != ExpectedFails) begin
						$display("error ResultOk low count exp %h got %h", ExpectedFails, lowCount);
						countError();
					end
					tests = tests + 1;
					if (testErrors != 0) begin
						failedTests = failedTests + 1;
					end
					$display("test %0d first %0d count %0d: %0d results, %0d errors", tests,
						testFirst, testLength, received, testErrors);
					armed = 1'b0;
				end
			end
			// the DUT takes Start only while idle
			if (Start && !armed) begin
				armed = 1'b1;
				expBucket = FirstBucket;
				testFirst = FirstBucket;
				testLength = BucketCount;
				remaining = int'(BucketCount);
				received = 0;
				lowCount = 0;
				testErrors = 0;
			end
		end
	end

endmodule

//--- tb/integrityTb.sv
`timescale 1ns/10ps

module integrityTb;

	import oramPkg::*;
	import hashPkg::*;

	localparam int NumEngines = 3;
	localparam int BucketWords = 4;
	localparam int FifoDepth = 4;
	localparam int NumBuckets = 32;
	localparam int Stride = BucketWords + 1;
	localparam int MemWords = NumBuckets * Stride;
	localparam int NumRows = 5;
	localparam int NoCopy = 255;

	typedef struct packed {
		bucketIdT first;
		bucketIdT count;
		logic [NumBuckets-1:0] corruptMask;
		bucketIdT copySrc;
		bucketIdT copyDst;
		logic [7:0] expectedFails;
	} testRowT;

	// first, count, corrupt mask, copy source, copy target, buckets expected to fail
	localparam testRowT TestTable [NumRows] = '{
		'{8'd5, 8'd1, 32'h0000_0000, 8'd0, 8'd255, 8'd0},
		'{8'd0, 8'd8, 32'h0000_0000, 8'd0, 8'd255, 8'd0},
		'{8'd10, 8'd6, 32'h0000_4800, 8'd0, 8'd255, 8'd2},
		'{8'd2, 8'd3, 32'h0000_0000, 8'd2, 8'd3, 8'd1},
		'{8'd4, 8'd24, 32'h0010_0200, 8'd0, 8'd255, 8'd2}
	};

	logic Clock;
	logic rst;
	logic HostWrite;
	addrT HostAddress;
	wordT HostData;
	logic Start;
	bucketIdT FirstBucket;
	bucketIdT BucketCount;
	logic ResultValid;
	bucketIdT ResultBucket;
	logic ResultOk;
	logic Done;

	int expectedFails;
	wordT image [MemWords];
	digestT modelTag [NumBuckets];
	int testCount;
	int failCount;
	int errorCount;
	logic [31:0] lfsrState;
	int cycleCount = 0;
	int cycleLimit;

	always #4 Clock = ~Clock;

	integrityTop #(
		.NumEngines(NumEngines),
		.BucketWords(BucketWords),
		.FifoDepth(FifoDepth)
	) integrityTop_i (
		.Clock(Clock),
		.rst(rst),
		.HostWrite(HostWrite),
		.HostAddress(HostAddress),
		.HostData(HostData),
		.Start(Start),
		.FirstBucket(FirstBucket),
		.BucketCount(BucketCount),
		.ResultValid(ResultValid),
		.ResultBucket(ResultBucket),
		.ResultOk(ResultOk),
		.Done(Done)
	);

	integrityChecker #(
		.BucketWords(BucketWords),
		.NumBuckets(NumBuckets)
	) integrityChecker_i (
		.Clock(Clock),
		.rst(rst),
		.Start(Start),
		.FirstBucket(FirstBucket),
		.BucketCount(BucketCount),
		.ResultValid(ResultValid),
		.ResultBucket(ResultBucket),
		.ResultOk(ResultOk),
		.Done(Done),
		.ExpectedFails(expectedFails),
		.Image(image),
		.ModelTag(modelTag),
		.TestCount(testCount),
		.FailCount(failCount),
		.ErrorCount(errorCount)
	);

	// ==============================
	// random data
	// ==============================

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic wordT randomWord();
		wordT w;
		w = '0;
		for (int i = 0; i < WordWidth; i++) begin
			lfsrState = lfsrStep(lfsrState);
			w = {w[WordWidth-2:0], lfsrState[0]};
		end
		return w;
	endfunction

	function automatic int timeoutLimit();
		int total;
		total = 200;
		for (int r = 0; r < NumRows; r++) begin
			// reset, memory fill and start come before the buckets
			total = total + 20 + MemWords;
			total = total + int'(TestTable[r].count) * (BucketWords + HashRounds + 8);
		end
		return total;
	endfunction

	// ==============================
	// test steps
	// ==============================

	task automatic resetDut();
		@(posedge Clock);
		rst <= 1'b1;
		repeat (5) @(posedge Clock);
		rst <= 1'b0;
	endtask

	task automatic fillMemory(testRowT row);
		for (int b = 0; b < NumBuckets; b++) begin
			for (int w = 0; w < BucketWords; w++) begin
				image[b * Stride + w] = randomWord();
			end
		end
		// model tags follow the new data words
		@(posedge Clock);
		for (int b = 0; b < NumBuckets; b++) begin
			image[b * Stride + BucketWords] = modelTag[b] ^ wordT'(row.corruptMask[b]);
		end
		// moved content keeps the tag of the bucket it came from
		if (row.copyDst != bucketIdT'(NoCopy)) begin
			for (int w = 0; w < Stride; w++) begin
				image[int'(row.copyDst) * Stride + w] = image[int'(row.copySrc) * Stride + w];
			end
		end
		for (int a = 0; a < MemWords; a++) begin
			@(posedge Clock);
			HostWrite <= 1'b1;
			HostAddress <= addrT'(a);
			HostData <= image[a];
		end
		@(posedge Clock);
		HostWrite <= 1'b0;
	endtask

	task automatic runRow(testRowT row);
		resetDut();
		fillMemory(row);
		@(posedge Clock);
		Start <= 1'b1;
		FirstBucket <= row.first;
		BucketCount <= row.count;
		expectedFails <= int'(row.expectedFails);
		@(posedge Clock);
		Start <= 1'b0;
		do begin
			@(posedge Clock);
		end while (!Done);
	endtask

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles, a run never reached Done", cycleCount);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		Clock = 1'b0;
		rst = 1'b1;
		HostWrite = 1'b0;
		HostAddress = '0;
		HostData = '0;
		Start = 1'b0;
		FirstBucket = '0;
		BucketCount = '0;
		expectedFails = 0;
		lfsrState = 32'h7b9ba26c;
		cycleLimit = timeoutLimit();
		for (int r = 0; r < NumRows; r++) begin
			runRow(TestTable[r]);
		end
		// idle so a late extra result is still caught
		repeat (20) @(posedge Clock);
		$display("%0d tests run, %0d failed, %0d errors", testCount, failCount, errorCount);
		if (errorCount == 0 && testCount == NumRows) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
